// File: rtl/remap_pkg.sv
package remap_pkg;

  // default word width in bits
  localparam int def_data_width = 16;

  // default number of single-port data banks, not counting the spare
  localparam int def_num_banks = 4;

  // default rows per bank; the spare bank has the same depth
  localparam int def_num_rows = 16;

  // where the current read is served from
  // src_bank reads the addressed data bank directly
  // src_spare reads the spare bank at the same row, since that row was relocated
  typedef enum logic {
    src_bank  = 1'b0,
    src_spare = 1'b1
  } read_src_e;

endpackage

// File: rtl/row_store.sv
module row_store #(
  parameter type payload_t = logic,
  parameter int num_rows = 16,
  parameter int num_rd = 1
) (
  input  logic clk,
  input  logic rst,

  // single write port
  input  logic wr_en,
  input  logic [$clog2(num_rows)-1:0] wr_row,
  input  payload_t wr_data,

  // num_rd asynchronous read ports, port i in slice i
  input  logic [num_rd-1:0][$clog2(num_rows)-1:0] rd_row,
  output payload_t [num_rd-1:0] rd_data
);

  localparam int row_w = $clog2(num_rows);

  payload_t mem [num_rows];

  // whole array clears on reset so unwritten rows read back as zero
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_rows; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_en) begin
      mem[wr_row] <= wr_data;
    end
  end

  // reads see the contents from before the current edge
  always_comb begin
    for (int i = 0; i < num_rd; i++) begin
      rd_data[i] = mem[rd_row[i][row_w-1:0]];
    end
  end

endmodule

// File: rtl/bank_set.sv
module bank_set #(
  parameter int data_width = 16,
  parameter int num_banks = 4,
  parameter int num_rows = 16
) (
  input  logic clk,
  input  logic rst,

  // write steering from the remap controller
  input  logic bank_wr_en,
  input  logic [$clog2(num_banks)-1:0] bank_wr_idx,
  input  logic bank_wr_evict,
  input  logic spare_wr_en,
  input  logic [$clog2(num_rows)-1:0] wr_row,
  input  logic [data_width-1:0] write_data,

  // read steering
  input  logic read_en,
  input  logic [$clog2(num_banks)-1:0] rd_bank,
  input  logic [$clog2(num_rows)-1:0] rd_row,
  input  remap_pkg::read_src_e rd_src,

  // registered read return, one cycle after read_en
  output logic rd_vld,
  output logic [data_width-1:0] rd_data
);

  import remap_pkg::*;

  typedef logic [data_width-1:0] word_t;

  word_t bank_rd_word [num_banks];
  word_t bank_wr_word;
  // slice 0 follows the read row, slice 1 the write row
  word_t [1:0] spare_rd_word;
  word_t rd_word;

  // an eviction moves the spare row's old word back to its home bank,
  // otherwise a bank write carries the new word
  assign bank_wr_word = bank_wr_evict ? spare_rd_word[1] : write_data;

  for (genvar b = 0; b < num_banks; b++) begin : g_bank
    logic bank_sel;

    assign bank_sel = bank_wr_en && (bank_wr_idx == b);

    row_store #(
      .payload_t (word_t),
      .num_rows  (num_rows),
      .num_rd    (1)
    ) bank0 (
      .clk     (clk),
      .rst     (rst),
      .wr_en   (bank_sel),
      .wr_row  (wr_row),
      .wr_data (bank_wr_word),
      .rd_row  (rd_row),
      .rd_data (bank_rd_word[b])
    );
  end

  // spare bank needs a second read port for the eviction word
  row_store #(
    .payload_t (word_t),
    .num_rows  (num_rows),
    .num_rd    (2)
  ) spare0 (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (spare_wr_en),
    .wr_row  (wr_row),
    .wr_data (write_data),
    .rd_row  ({wr_row, rd_row}),
    .rd_data (spare_rd_word)
  );

  assign rd_word = (rd_src == src_spare) ? spare_rd_word[0] : bank_rd_word[rd_bank];

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_vld <= 1'b0;
    end else begin
      rd_vld <= read_en;
    end
  end

  // data holds its last value between reads
  always_ff @(posedge clk) begin
    if (read_en) begin
      rd_data <= rd_word;
    end
  end

endmodule

// File: rtl/remap_ctrl.sv
module remap_ctrl #(
  parameter int num_banks = 4,
  parameter int num_rows = 16
) (
  input  logic clk,
  input  logic rst,

  // logical requests, bank index in the upper bits
  input  logic read_en,
  input  logic [$clog2(num_banks)+$clog2(num_rows)-1:0] read_addr,
  input  logic write_en,
  input  logic [$clog2(num_banks)+$clog2(num_rows)-1:0] write_addr,

  // write steering
  output logic bank_wr_en,
  output logic [$clog2(num_banks)-1:0] bank_wr_idx,
  output logic bank_wr_evict,
  output logic spare_wr_en,
  output logic [$clog2(num_rows)-1:0] wr_row,

  // read steering
  output logic [$clog2(num_banks)-1:0] rd_bank,
  output logic [$clog2(num_rows)-1:0] rd_row,
  output remap_pkg::read_src_e rd_src
);

  import remap_pkg::*;

  localparam int bank_w = $clog2(num_banks);
  localparam int row_w = $clog2(num_rows);
  localparam int addr_w = bank_w + row_w;

  // which bank's row currently lives in the spare bank
  typedef struct packed {
    logic vld;
    logic [bank_w-1:0] bank;
  } map_entry_t;

  logic [bank_w-1:0] r_bank;
  logic [row_w-1:0] r_row;
  logic [bank_w-1:0] w_bank;
  logic [row_w-1:0] w_row;

  // slice 0 is the entry at the read row, slice 1 at the write row
  map_entry_t [1:0] map_rd;
  map_entry_t map_r;
  map_entry_t map_w;
  map_entry_t map_new;
  logic map_wr_en;

  logic conflict;
  logic w_in_spare;

  assign r_bank = read_addr[addr_w-1:row_w];
  assign r_row = read_addr[row_w-1:0];
  assign w_bank = write_addr[addr_w-1:row_w];
  assign w_row = write_addr[row_w-1:0];

  row_store #(
    .payload_t (map_entry_t),
    .num_rows  (num_rows),
    .num_rd    (2)
  ) map0 (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (map_wr_en),
    .wr_row  (w_row),
    .wr_data (map_new),
    .rd_row  ({w_row, r_row}),
    .rd_data (map_rd)
  );

  assign map_r = map_rd[0];
  assign map_w = map_rd[1];

  // the data bank is single ported, so a write to the bank being read
  // has to go somewhere else this cycle
  assign conflict = read_en && write_en && (w_bank == r_bank);

  // write row of the write bank is already held by the spare
  assign w_in_spare = map_w.vld && (map_w.bank == w_bank);

  always_comb begin
    bank_wr_en = 1'b0;
    bank_wr_idx = w_bank;
    bank_wr_evict = 1'b0;
    spare_wr_en = 1'b0;
    map_wr_en = 1'b0;
    map_new.vld = 1'b1;
    map_new.bank = w_bank;

    if (write_en) begin
      if (!conflict) begin
        // keep a relocated row in the spare, else write home
        if (w_in_spare) begin
          spare_wr_en = 1'b1;
        end else begin
          bank_wr_en = 1'b1;
        end
      end else begin
        spare_wr_en = 1'b1;
        map_wr_en = 1'b1;
        // spare row belongs to another bank, which is idle this cycle
        if (map_w.vld && !w_in_spare) begin
          bank_wr_en = 1'b1;
          bank_wr_idx = map_w.bank;
          bank_wr_evict = 1'b1;
        end
      end
    end
  end

  assign wr_row = w_row;
  assign rd_bank = r_bank;
  assign rd_row = r_row;

  // map lookup uses the entry from before this edge, matching the old data
  assign rd_src = (map_r.vld && (map_r.bank == r_bank)) ? src_spare : src_bank;

endmodule

// File: rtl/remap_mem_top.sv
module remap_mem_top #(
  parameter int data_width = remap_pkg::def_data_width,
  parameter int num_banks = remap_pkg::def_num_banks,
  parameter int num_rows = remap_pkg::def_num_rows
) (
  input  logic clk,
  input  logic rst,

  // read port
  input  logic read_en,
  input  logic [$clog2(num_banks)+$clog2(num_rows)-1:0] read_addr,

  // write port
  input  logic write_en,
  input  logic [$clog2(num_banks)+$clog2(num_rows)-1:0] write_addr,
  input  logic [data_width-1:0] write_data,

  // read return
  output logic rd_vld,
  output logic [data_width-1:0] rd_data
);

  import remap_pkg::*;

  localparam int bank_w = $clog2(num_banks);
  localparam int row_w = $clog2(num_rows);

  // steering from controller to storage
  logic bank_wr_en;
  logic [bank_w-1:0] bank_wr_idx;
  logic bank_wr_evict;
  logic spare_wr_en;
  logic [row_w-1:0] wr_row;
  logic [bank_w-1:0] rd_bank;
  logic [row_w-1:0] rd_row;
  read_src_e rd_src;

  remap_ctrl #(
    .num_banks (num_banks),
    .num_rows  (num_rows)
  ) ctrl0 (
    .clk           (clk),
    .rst           (rst),
    .read_en       (read_en),
    .read_addr     (read_addr),
    .write_en      (write_en),
    .write_addr    (write_addr),
    .bank_wr_en    (bank_wr_en),
    .bank_wr_idx   (bank_wr_idx),
    .bank_wr_evict (bank_wr_evict),
    .spare_wr_en   (spare_wr_en),
    .wr_row        (wr_row),
    .rd_bank       (rd_bank),
    .rd_row        (rd_row),
    .rd_src        (rd_src)
  );

  // write data and read enable come straight from the ports
  bank_set #(
    .data_width (data_width),
    .num_banks  (num_banks),
    .num_rows   (num_rows)
  ) banks0 (
    .clk           (clk),
    .rst           (rst),
    .bank_wr_en    (bank_wr_en),
    .bank_wr_idx   (bank_wr_idx),
    .bank_wr_evict (bank_wr_evict),
    .spare_wr_en   (spare_wr_en),
    .wr_row        (wr_row),
    .write_data    (write_data),
    .read_en       (read_en),
    .rd_bank       (rd_bank),
    .rd_row        (rd_row),
    .rd_src        (rd_src),
    .rd_vld        (rd_vld),
    .rd_data       (rd_data)
  );

endmodule

// File: test/remap_mem_tb.sv
module remap_mem_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import remap_pkg::*;

  localparam int data_width = def_data_width;
  localparam int num_banks = def_num_banks;
  localparam int num_rows = def_num_rows;
  localparam int bank_w = $clog2(num_banks);
  localparam int row_w = $clog2(num_rows);
  localparam int addr_w = bank_w + row_w;
  localparam int num_addrs = num_banks * num_rows;

  // phase tags that travel with each request into the model
  localparam int ph_idle = 0;
  localparam int ph_zero = 1;
  localparam int ph_random = 2;
  localparam int ph_conflict = 3;
  localparam int ph_evict = 4;
  localparam int ph_same = 5;
  localparam int ph_readback = 6;

  // cycles issued by each phase
  localparam int n_reset = 2;
  localparam int n_idle = 3;
  localparam int n_random = 200;
  localparam int n_conflict = 150;
  localparam int n_evict_rows = 4;
  localparam int n_evict = n_evict_rows * 3 * num_banks;
  localparam int n_same = 30;
  localparam int n_drain = 4;
  localparam int total_cycles = n_reset + n_idle + num_addrs + n_random + n_conflict
    + n_evict + 2 * n_same + num_addrs + n_drain;

  logic clk;
  logic rst;
  logic read_en;
  logic [addr_w-1:0] read_addr;
  logic write_en;
  logic [addr_w-1:0] write_addr;
  logic [data_width-1:0] write_data;
  logic rd_vld;
  logic [data_width-1:0] rd_data;

  int phase;
  logic [31:0] rng;

  // reference model whose read result lags its request by one cycle
  logic [data_width-1:0] ref_mem [num_addrs];
  logic exp_vld;
  logic [data_width-1:0] exp_data;
  int exp_phase;
  int reads_done = 0;

  int vld_errors = 0;
  int data_errors = 0;
  int zero_errors = 0;

  remap_mem_top dut0 (
    .clk        (clk),
    .rst        (rst),
    .read_en    (read_en),
    .read_addr  (read_addr),
    .write_en   (write_en),
    .write_addr (write_addr),
    .write_data (write_data),
    .rd_vld     (rd_vld),
    .rd_data    (rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic string phase_name(input int ph);
    case (ph)
      ph_zero: return "zero_after_reset";
      ph_random: return "random_traffic";
      ph_conflict: return "same_bank_conflict";
      ph_evict: return "spare_eviction";
      ph_same: return "same_address_rw";
      ph_readback: return "final_readback";
      default: return "idle";
    endcase
  endfunction

  task automatic next_random(output logic [31:0] val);
    rng = xorshift32(rng);
    val = rng;
  endtask

  task automatic drive_request(input logic re, input logic [addr_w-1:0] ra,
                               input logic we, input logic [addr_w-1:0] wa,
                               input logic [data_width-1:0] wd, input int ph);
    @(posedge clk);
    read_en <= re;
    read_addr <= ra;
    write_en <= we;
    write_addr <= wa;
    write_data <= wd;
    phase <= ph;
  endtask

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_addrs; i++) begin
        ref_mem[i] <= '0;
      end
      exp_vld <= 1'b0;
      exp_data <= '0;
      exp_phase <= ph_idle;
    end else begin
      exp_vld <= read_en;
      exp_phase <= phase;
      // read sees the word from before this edge
      if (read_en) begin
        exp_data <= ref_mem[read_addr];
        reads_done <= reads_done + 1;
      end
      if (write_en) begin
        ref_mem[write_addr] <= write_data;
      end
    end
  end

  vld_check: assert property (@(posedge clk) disable iff (rst) rd_vld == exp_vld)
    else begin
      vld_errors++;
      $display("** Error read_valid: expected %0b actual %0b",
               $sampled(exp_vld), $sampled(rd_vld));
    end

  data_check: assert property (@(posedge clk) disable iff (rst)
      exp_vld |-> rd_data == exp_data)
    else begin
      data_errors++;
      $display("** Error %s: expected %h actual %h", phase_name($sampled(exp_phase)),
               $sampled(exp_data), $sampled(rd_data));
    end

  // nothing written yet, so the word must be zero
  zero_check: assert property (@(posedge clk) disable iff (rst)
      (exp_vld && exp_phase == ph_zero) |-> rd_data == '0)
    else begin
      zero_errors++;
      $display("** Error zero_after_reset: expected %h actual %h",
               {data_width{1'b0}}, $sampled(rd_data));
    end

  task automatic check_reset_state();
    // rd_vld has to stay low while no read is issued
    for (int i = 0; i < n_idle; i++) begin
      drive_request(1'b0, '0, 1'b0, '0, '0, ph_idle);
    end
    for (int a = 0; a < num_addrs; a++) begin
      drive_request(1'b1, addr_w'(a), 1'b0, '0, '0, ph_zero);
    end
  endtask

  task automatic send_random_traffic();
    logic [31:0] r;
    logic [addr_w-1:0] ra;
    logic [addr_w-1:0] wa;
    logic [addr_w-1:0] last_wa;
    logic re;
    logic we;
    last_wa = '0;
    for (int i = 0; i < n_random; i++) begin
      next_random(r);
      re = r[0] | r[1];
      we = r[2] | r[3];
      // half of the reads go back to an earlier write
      ra = r[4] ? last_wa : r[8 +: addr_w];
      wa = r[16 +: addr_w];
      if (re && we && (wa[addr_w-1:row_w] == ra[addr_w-1:row_w])) begin
        wa[addr_w-1:row_w] = ra[addr_w-1:row_w] + 1'b1;
      end
      next_random(r);
      drive_request(re, ra, we, wa, r[data_width-1:0], ph_random);
      if (we) begin
        last_wa = wa;
      end
    end
  endtask

  task automatic provoke_conflicts();
    logic [31:0] r;
    logic [addr_w-1:0] ra;
    logic [addr_w-1:0] wa;
    for (int i = 0; i < n_conflict; i++) begin
      next_random(r);
      ra = r[0 +: addr_w];
      wa = r[8 +: addr_w];
      wa[addr_w-1:row_w] = ra[addr_w-1:row_w];
      if (wa[row_w-1:0] == ra[row_w-1:0]) begin
        wa[row_w-1:0] = ra[row_w-1:0] + 1'b1;
      end
      next_random(r);
      drive_request(1'b1, ra, 1'b1, wa, r[data_width-1:0], ph_conflict);
    end
  endtask

  task automatic force_evictions();
    logic [31:0] r;
    logic [row_w-1:0] row;
    logic [bank_w-1:0] first;
    logic [bank_w-1:0] b;
    for (int k = 0; k < n_evict_rows; k++) begin
      next_random(r);
      row = r[row_w-1:0];
      first = r[8 +: bank_w];
      // two rounds in which each write pushes the previous bank's word home
      for (int i = 0; i < 2 * num_banks; i++) begin
        b = first + bank_w'(i);
        next_random(r);
        drive_request(1'b1, {b, row ^ row_w'(1)}, 1'b1, {b, row}, r[data_width-1:0],
                      ph_evict);
      end
      for (int i = 0; i < num_banks; i++) begin
        drive_request(1'b1, {bank_w'(i), row}, 1'b0, '0, '0, ph_evict);
      end
    end
  endtask

  task automatic write_then_read_same();
    logic [31:0] r;
    logic [addr_w-1:0] a;
    for (int i = 0; i < n_same; i++) begin
      next_random(r);
      a = r[0 +: addr_w];
      next_random(r);
      drive_request(1'b1, a, 1'b1, a, r[data_width-1:0], ph_same);
      drive_request(1'b1, a, 1'b0, '0, '0, ph_same);
    end
  endtask

  task automatic read_all_addresses();
    for (int a = 0; a < num_addrs; a++) begin
      drive_request(1'b1, addr_w'(a), 1'b0, '0, '0, ph_readback);
    end
  endtask

  initial begin
    rst = 1'b1;
    read_en = 1'b0;
    read_addr = '0;
    write_en = 1'b0;
    write_addr = '0;
    write_data = '0;
    phase = ph_idle;
    rng = 32'd57613;

    repeat (n_reset) @(posedge clk);
    rst <= 1'b0;

    check_reset_state();
    send_random_traffic();
    provoke_conflicts();
    force_evictions();
    write_then_read_same();
    read_all_addresses();
    for (int i = 0; i < n_drain; i++) begin
      drive_request(1'b0, '0, 1'b0, '0, '0, ph_idle);
    end

    $display("reads %0d, valid errors %0d, data errors %0d, zero errors %0d",
             reads_done, vld_errors, data_errors, zero_errors);
    if (vld_errors == 0 && data_errors == 0 && zero_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // run length is fixed by the phase budgets above
  initial begin
    #(20 * total_cycles + 500);
    $display("watchdog expired after %0d cycles, run did not complete", total_cycles);
    $display("Finished with errors");
    $finish;
  end

endmodule

// File: sources.f
rtl/remap_pkg.sv
rtl/row_store.sv
rtl/bank_set.sv
rtl/remap_ctrl.sv
rtl/remap_mem_top.sv
test/remap_mem_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the remap memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module remap_mem_tb -f sources.f -o remap_mem_sim
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

sim_out=$(./obj_dir/remap_mem_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Finished with no errors" <<< "$sim_out"; then
  exit 0
fi

echo "simulation did not report a clean run"
exit 1
